// File: rtl/PipeCtrlPkg.sv
////////////////////////////////////////
// Pipeline control package
// Instruction descriptor, hazard flags, stage masks,
// control command and stall cause encoding
////////////////////////////////////////

package PipeCtrlPkg;

    // Architectural register index width
    localparam int unsigned RegAddrW = 5;

    // One instruction as seen by the control logic
    typedef struct packed {
        logic                valid;
        logic [RegAddrW-1:0] dstReg;
        logic                isLoad;
        logic [RegAddrW-1:0] src0Reg;
        logic                src0Used;
        logic [RegAddrW-1:0] src1Reg;
        logic                src1Used;
    } instrInfoT;

    // Load-use hits, one per younger stage
    typedef struct packed {
        logic exLoadHit;
        logic mem1LoadHit;
        logic mem2LoadHit;
    } hazardT;

    // One bit per stage, front to back
    typedef struct packed {
        logic preIf;
        logic ifS;
        logic id;
        logic ex;
        logic mem1;
        logic mem2;
        logic wb;
    } stageMaskT;

    // Full command to the pipeline and caches
    typedef struct packed {
        stageMaskT wr;
        stageMaskT flush;
        logic      idDisWr;
        logic      exDisWr;
        logic      memDisWr;
        logic      wbDisWr;
        logic      icacheFlush;
        logic      iReqValid;
        logic      dReqValid;
        logic      icacheStall;
        logic      dcacheStall;
    } ctrlCmdT;

    // Winning cause, highest priority first
    typedef enum logic [3:0] {
        causeDcache,
        causeIcache,
        causeMulDiv,
        causeException,
        causeMem2Hazard,
        causeMem1Hazard,
        causeExHazard,
        causeBranch,
        causeJump,
        causeNone
    } stallCauseE;

endpackage

// File: rtl/HazardDetect.sv
////////////////////////////////////////
// Load-use hazard detector
// Compares ID sources against loads in EX, MEM1, MEM2
////////////////////////////////////////

`timescale 1ns/100ps

module HazardDetect import PipeCtrlPkg::*; (
    input  instrInfoT idInstr,
    input  instrInfoT exInstr,
    input  instrInfoT mem1Instr,
    input  instrInfoT mem2Instr,
    output hazardT    hazard
);

    // Pending load in one stage against the ID reader
    function automatic logic loadUseHit(
        input instrInfoT older,
        input instrInfoT reader
    );
        logic pendingLoad;
        logic src0Hit;
        logic src1Hit;
        // Only a real load with a nonzero target can stall
        pendingLoad = older.valid && older.isLoad && (older.dstReg != '0);
        // Unused source fields carry junk, never compare them
        src0Hit = reader.src0Used && (reader.src0Reg == older.dstReg);
        src1Hit = reader.src1Used && (reader.src1Reg == older.dstReg);
        return reader.valid && pendingLoad && (src0Hit || src1Hit);
    endfunction

    logic exHit;
    logic mem1Hit;
    logic mem2Hit;

    // Each stage checked on its own
    always_comb begin
        exHit   = loadUseHit(exInstr, idInstr);
        mem1Hit = loadUseHit(mem1Instr, idInstr);
        mem2Hit = loadUseHit(mem2Instr, idInstr);
    end

    // All three reported, controller picks the winner
    always_comb begin
        hazard.exLoadHit   = exHit;
        hazard.mem1LoadHit = mem1Hit;
        hazard.mem2LoadHit = mem2Hit;
    end

endmodule

// File: rtl/StallFlushCtrl.sv
////////////////////////////////////////
// Stall and flush controller
// Picks the highest priority cause and
// maps it to the pipeline command row
////////////////////////////////////////

`timescale 1ns/100ps

module StallFlushCtrl import PipeCtrlPkg::*; (
    input  hazardT   hazard,
    input  logic     flushException,
    input  logic     iTlbStall,
    input  logic     dTlbStall,
    input  logic     icacheBusy,
    input  logic     dcacheBusy,
    input  logic     mulDivBusy,
    input  logic     branchFailed,
    input  logic     idIsImmJump,
    output ctrlCmdT  ctrlCmd
);

    stallCauseE cause;

    // Fixed priority, data side first
    always_comb begin
        if (dcacheBusy || dTlbStall) begin
            cause = causeDcache;
        end else if (icacheBusy || iTlbStall) begin
            cause = causeIcache;
        end else if (mulDivBusy) begin
            cause = causeMulDiv;
        end else if (flushException) begin
            cause = causeException;
        end else if (hazard.mem2LoadHit) begin
            cause = causeMem2Hazard;
        end else if (hazard.mem1LoadHit) begin
            cause = causeMem1Hazard;
        end else if (hazard.exLoadHit) begin
            cause = causeExHazard;
        end else if (branchFailed) begin
            cause = causeBranch;
        end else if (idIsImmJump) begin
            cause = causeJump;
        end else begin
            cause = causeNone;
        end
    end

    // Cause to command row
    always_comb begin
        // Start from the free-running row
        ctrlCmd           = '0;
        ctrlCmd.wr        = '1;
        ctrlCmd.iReqValid = 1'b1;
        ctrlCmd.dReqValid = 1'b1;
        case (cause)
            causeDcache, causeIcache, causeMulDiv: begin
                // Whole pipe frozen, caches hold their data
                ctrlCmd.wr          = '0;
                ctrlCmd.exDisWr     = (cause == causeMulDiv);
                ctrlCmd.memDisWr    = 1'b1;
                ctrlCmd.wbDisWr     = 1'b1;
                ctrlCmd.icacheStall = 1'b1;
                ctrlCmd.dcacheStall = 1'b1;
            end
            causeException: begin
                // Redirect fetch, drop everything before MEM2
                ctrlCmd.wr          = '{preIf: 1'b1, mem2: 1'b1, wb: 1'b1, default: 1'b0};
                ctrlCmd.flush       = '{ifS: 1'b1, id: 1'b1, ex: 1'b1, mem1: 1'b1,
                                        default: 1'b0};
                ctrlCmd.icacheFlush = 1'b1;
                ctrlCmd.iReqValid   = 1'b0;
                ctrlCmd.dReqValid   = 1'b0;
                ctrlCmd.exDisWr     = 1'b1;
                ctrlCmd.memDisWr    = 1'b1;
            end
            causeMem2Hazard: begin
                // Only MEM2 and WB drain
                ctrlCmd.wr          = '{mem2: 1'b1, wb: 1'b1, default: 1'b0};
                ctrlCmd.memDisWr    = 1'b1;
                ctrlCmd.iReqValid   = 1'b0;
                ctrlCmd.icacheStall = 1'b1;
            end
            causeMem1Hazard: begin
                ctrlCmd.wr          = '{mem1: 1'b1, mem2: 1'b1, wb: 1'b1, default: 1'b0};
                ctrlCmd.exDisWr     = 1'b1;
                ctrlCmd.iReqValid   = 1'b0;
                ctrlCmd.icacheStall = 1'b1;
            end
            causeExHazard: begin
                // Front end holds, EX takes a bubble
                ctrlCmd.wr          = '{ex: 1'b1, mem1: 1'b1, mem2: 1'b1, wb: 1'b1,
                                        default: 1'b0};
                ctrlCmd.idDisWr     = 1'b1;
                ctrlCmd.iReqValid   = 1'b0;
                ctrlCmd.icacheStall = 1'b1;
            end
            causeBranch: begin
                // Mispredict kills two wrong-path slots
                ctrlCmd.wr.ifS      = 1'b0;
                ctrlCmd.wr.id       = 1'b0;
                ctrlCmd.flush.ifS   = 1'b1;
                ctrlCmd.flush.id    = 1'b1;
                ctrlCmd.icacheFlush = 1'b1;
                ctrlCmd.iReqValid   = 1'b0;
            end
            causeJump: begin
                // One slot lost behind a jump in ID
                ctrlCmd.wr.ifS      = 1'b0;
                ctrlCmd.flush.ifS   = 1'b1;
                ctrlCmd.icacheFlush = 1'b1;
                ctrlCmd.iReqValid   = 1'b0;
            end
            default: begin
                // causeNone keeps the free-running row
            end
        endcase
    end

endmodule

// File: rtl/StageTrack.sv
////////////////////////////////////////
// Stage descriptor tracker
// Follows instructions through EX to WB
////////////////////////////////////////

`timescale 1ns/100ps

module StageTrack import PipeCtrlPkg::*; (
    input  logic      clk,
    input  logic      arstN,
    input  instrInfoT idInstr,
    input  ctrlCmdT   ctrlCmd,
    output instrInfoT exInstr,
    output instrInfoT mem1Instr,
    output instrInfoT mem2Instr,
    output instrInfoT wbInstr
);

    // Next descriptor for one stage
    function automatic instrInfoT nextStage(
        input instrInfoT cur,
        input instrInfoT pred,
        input logic      flushBit,
        input logic      wrBit,
        input logic      predWr
    );
        instrInfoT nxt;
        if (flushBit) begin
            // Flushed slot becomes empty
            nxt = '0;
        end else if (!wrBit) begin
            nxt = cur;
        end else if (!predWr) begin
            // Predecessor frozen, insert a bubble
            nxt = '0;
        end else begin
            nxt = pred;
        end
        return nxt;
    endfunction

    instrInfoT exNext;
    instrInfoT mem1Next;
    instrInfoT mem2Next;
    instrInfoT wbNext;

    // Each stage looks at its own and its predecessor's enable
    always_comb begin
        exNext   = nextStage(exInstr, idInstr, ctrlCmd.flush.ex,
                             ctrlCmd.wr.ex, ctrlCmd.wr.id);
        mem1Next = nextStage(mem1Instr, exInstr, ctrlCmd.flush.mem1,
                             ctrlCmd.wr.mem1, ctrlCmd.wr.ex);
        mem2Next = nextStage(mem2Instr, mem1Instr, ctrlCmd.flush.mem2,
                             ctrlCmd.wr.mem2, ctrlCmd.wr.mem1);
        wbNext   = nextStage(wbInstr, mem2Instr, ctrlCmd.flush.wb,
                             ctrlCmd.wr.wb, ctrlCmd.wr.mem2);
    end

    // Empty pipe out of reset
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            exInstr   <= '0;
            mem1Instr <= '0;
            mem2Instr <= '0;
            wbInstr   <= '0;
        end else begin
            exInstr   <= exNext;
            mem1Instr <= mem1Next;
            mem2Instr <= mem2Next;
            wbInstr   <= wbNext;
        end
    end

endmodule

// File: rtl/PipeCtrlTop.sv
////////////////////////////////////////
// Pipeline control top level
// Hazard detect, stall control, stage tracking
////////////////////////////////////////

`timescale 1ns/100ps

module PipeCtrlTop import PipeCtrlPkg::*; (
    input  logic      clk,
    input  logic      arstN,
    input  instrInfoT idInstr,
    input  logic      flushException,
    input  logic      iTlbStall,
    input  logic      dTlbStall,
    input  logic      icacheBusy,
    input  logic      dcacheBusy,
    input  logic      mulDivBusy,
    input  logic      branchFailed,
    input  logic      idIsImmJump,
    output ctrlCmdT   ctrlCmd,
    output instrInfoT wbInstr
);

    // Tracked descriptors feeding the comparators
    instrInfoT exInstr;
    instrInfoT mem1Instr;
    instrInfoT mem2Instr;
    hazardT    hazard;

    HazardDetect uHazardDetect (
        .idInstr   (idInstr),
        .exInstr   (exInstr),
        .mem1Instr (mem1Instr),
        .mem2Instr (mem2Instr),
        .hazard    (hazard)
    );

    // Same-cycle command, no register after the hazard check
    StallFlushCtrl uStallFlushCtrl (
        .hazard         (hazard),
        .flushException (flushException),
        .iTlbStall      (iTlbStall),
        .dTlbStall      (dTlbStall),
        .icacheBusy     (icacheBusy),
        .dcacheBusy     (dcacheBusy),
        .mulDivBusy     (mulDivBusy),
        .branchFailed   (branchFailed),
        .idIsImmJump    (idIsImmJump),
        .ctrlCmd        (ctrlCmd)
    );

    StageTrack uStageTrack (
        .clk       (clk),
        .arstN     (arstN),
        .idInstr   (idInstr),
        .ctrlCmd   (ctrlCmd),
        .exInstr   (exInstr),
        .mem1Instr (mem1Instr),
        .mem2Instr (mem2Instr),
        .wbInstr   (wbInstr)
    );

endmodule

// File: bench/PipeCtrlTb.sv
////////////////////////////////////////
// Pipeline control testbench
// Random and directed stimulus against a
// reference model of the tracker and priority rows
////////////////////////////////////////

`timescale 1ns/100ps

module PipeCtrlTb import PipeCtrlPkg::*; ();

    localparam int ClkPeriod = 40;

    // Stall and redirect levels into the DUT
    typedef struct packed {
        logic flushException;
        logic iTlbStall;
        logic dTlbStall;
        logic icacheBusy;
        logic dcacheBusy;
        logic mulDivBusy;
        logic branchFailed;
        logic idIsImmJump;
    } stallInT;

    logic      clk;
    logic      arstN;
    instrInfoT idInstr;
    stallInT   stallIn;
    ctrlCmdT   ctrlCmd;
    instrInfoT wbInstr;

    // Model copies of the tracked stages
    instrInfoT mEx;
    instrInfoT mMem1;
    instrInfoT mMem2;
    instrInfoT mWb;

    integer seed;
    int     errCount;
    int     checkCount;

    PipeCtrlTop dut (
        .clk            (clk),
        .arstN          (arstN),
        .idInstr        (idInstr),
        .flushException (stallIn.flushException),
        .iTlbStall      (stallIn.iTlbStall),
        .dTlbStall      (stallIn.dTlbStall),
        .icacheBusy     (stallIn.icacheBusy),
        .dcacheBusy     (stallIn.dcacheBusy),
        .mulDivBusy     (stallIn.mulDivBusy),
        .branchFailed   (stallIn.branchFailed),
        .idIsImmJump    (stallIn.idIsImmJump),
        .ctrlCmd        (ctrlCmd),
        .wbInstr        (wbInstr)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    task automatic checkCmd(input ctrlCmdT got, input ctrlCmdT exp, input string name);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("mismatch at %0t: %s got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkInstr(input instrInfoT got, input instrInfoT exp, input string name);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("mismatch at %0t: %s got %h, expected %h", $time, name, got, exp);
        end
    endtask

    // Load in an older stage against the ID reader
    function automatic logic modelHit(input instrInfoT older, input instrInfoT id);
        logic readsDst;
        readsDst = (id.src0Used && id.src0Reg == older.dstReg) ||
                   (id.src1Used && id.src1Reg == older.dstReg);
        return id.valid && older.valid && older.isLoad && older.dstReg != 0 && readsDst;
    endfunction

    function automatic stallCauseE modelCause();
        if (stallIn.dcacheBusy || stallIn.dTlbStall) return causeDcache;
        if (stallIn.icacheBusy || stallIn.iTlbStall) return causeIcache;
        if (stallIn.mulDivBusy) return causeMulDiv;
        if (stallIn.flushException) return causeException;
        if (modelHit(mMem2, idInstr)) return causeMem2Hazard;
        if (modelHit(mMem1, idInstr)) return causeMem1Hazard;
        if (modelHit(mEx, idInstr)) return causeExHazard;
        if (stallIn.branchFailed) return causeBranch;
        if (stallIn.idIsImmJump) return causeJump;
        return causeNone;
    endfunction

    // Row per cause, masks ordered preIf down to wb
    function automatic ctrlCmdT expectedRow(input stallCauseE c);
        ctrlCmdT r;
        r = '0;
        r.iReqValid = 1'b1;
        r.dReqValid = 1'b1;
        case (c)
            causeDcache, causeIcache, causeMulDiv: begin
                r.exDisWr     = (c == causeMulDiv);
                r.memDisWr    = 1'b1;
                r.wbDisWr     = 1'b1;
                r.icacheStall = 1'b1;
                r.dcacheStall = 1'b1;
            end
            causeException: begin
                r.wr          = 7'b1000011;
                r.flush       = 7'b0111100;
                r.icacheFlush = 1'b1;
                r.iReqValid   = 1'b0;
                r.dReqValid   = 1'b0;
                r.exDisWr     = 1'b1;
                r.memDisWr    = 1'b1;
            end
            causeMem2Hazard, causeMem1Hazard, causeExHazard: begin
                r.wr          = (c == causeMem2Hazard) ? 7'b0000011 :
                                (c == causeMem1Hazard) ? 7'b0000111 : 7'b0001111;
                r.memDisWr    = (c == causeMem2Hazard);
                r.exDisWr     = (c == causeMem1Hazard);
                r.idDisWr     = (c == causeExHazard);
                r.iReqValid   = 1'b0;
                r.icacheStall = 1'b1;
            end
            causeBranch, causeJump: begin
                r.wr          = (c == causeBranch) ? 7'b1001111 : 7'b1011111;
                r.flush       = (c == causeBranch) ? 7'b0110000 : 7'b0100000;
                r.icacheFlush = 1'b1;
                r.iReqValid   = 1'b0;
            end
            default: r.wr = 7'h7f;
        endcase
        return r;
    endfunction

    // Tracker rule at one clock edge
    task automatic advanceModel(input ctrlCmdT c);
        instrInfoT nEx;
        instrInfoT nMem1;
        instrInfoT nMem2;
        instrInfoT nWb;
        nEx   = c.flush.ex   ? '0 : !c.wr.ex   ? mEx   : c.wr.id   ? idInstr : '0;
        nMem1 = c.flush.mem1 ? '0 : !c.wr.mem1 ? mMem1 : c.wr.ex   ? mEx     : '0;
        nMem2 = c.flush.mem2 ? '0 : !c.wr.mem2 ? mMem2 : c.wr.mem1 ? mMem1   : '0;
        nWb   = c.flush.wb   ? '0 : !c.wr.wb   ? mWb   : c.wr.mem2 ? mMem2   : '0;
        mEx   = nEx;
        mMem1 = nMem1;
        mMem2 = nMem2;
        mWb   = nWb;
    endtask

    task automatic checkAndAdvance();
        ctrlCmdT exp;
        exp = expectedRow(modelCause());
        checkCmd(ctrlCmd, exp, "ctrlCmd");
        checkInstr(wbInstr, mWb, "wbInstr");
        advanceModel(exp);
    endtask

    // Drive on the falling edge, check once settled
    task automatic stepCycle(input instrInfoT id, input stallInT st);
        @(negedge clk);
        idInstr = id;
        stallIn = st;
        #(ClkPeriod / 4);
        checkAndAdvance();
    endtask

    function automatic instrInfoT makeInstr(input logic [RegAddrW-1:0] dst, input logic load,
                                            input logic [RegAddrW-1:0] s0, input logic u0,
                                            input logic [RegAddrW-1:0] s1, input logic u1);
        return '{valid: 1'b1, dstReg: dst, isLoad: load, src0Reg: s0, src0Used: u0,
                 src1Reg: s1, src1Used: u1};
    endfunction

    // Registers 0..3 only, so hazards come often
    function automatic instrInfoT randomInstr();
        instrInfoT r;
        r.valid    = ($random(seed) & 3) != 0;
        r.dstReg   = RegAddrW'($random(seed) & 3);
        r.isLoad   = ($random(seed) & 1) != 0;
        r.src0Reg  = RegAddrW'($random(seed) & 3);
        r.src0Used = ($random(seed) & 1) != 0;
        r.src1Reg  = RegAddrW'($random(seed) & 3);
        r.src1Used = ($random(seed) & 1) != 0;
        return r;
    endfunction

    // Rare stalls so that every priority level shows up
    function automatic stallInT randomStalls();
        stallInT s;
        s.flushException = ($random(seed) & 31) == 0;
        s.iTlbStall      = ($random(seed) & 63) == 0;
        s.dTlbStall      = ($random(seed) & 63) == 0;
        s.icacheBusy     = ($random(seed) & 31) == 0;
        s.dcacheBusy     = ($random(seed) & 31) == 0;
        s.mulDivBusy     = ($random(seed) & 31) == 0;
        s.branchFailed   = ($random(seed) & 15) == 0;
        s.idIsImmJump    = ($random(seed) & 15) == 0;
        return s;
    endfunction

    initial begin
        instrInfoT marker;
        int        waitCount;
        seed       = 32'he33a;
        errCount   = 0;
        checkCount = 0;
        arstN      = 1'b0;
        idInstr    = '0;
        stallIn    = '0;
        mEx        = '0;
        mMem1      = '0;
        mMem2      = '0;
        mWb        = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        #(ClkPeriod / 4);
        // Idle pipe right after reset
        checkCmd(ctrlCmd, expectedRow(causeNone), "ctrlCmd after reset");
        checkInstr(wbInstr, '0, "wbInstr after reset");
        checkAndAdvance();

        // Load then a reader of its target, walks EX, MEM1, MEM2
        stepCycle(makeInstr(5'd5, 1'b1, 5'd1, 1'b1, 5'd2, 1'b0), '0);
        stepCycle(makeInstr(5'd6, 1'b0, 5'd5, 1'b1, 5'd3, 1'b1), '0);
        checkCmd(ctrlCmd, expectedRow(causeExHazard), "ctrlCmd ex hazard");
        stepCycle(idInstr, '0);
        checkCmd(ctrlCmd, expectedRow(causeMem1Hazard), "ctrlCmd mem1 hazard");
        stepCycle(idInstr, '0);
        checkCmd(ctrlCmd, expectedRow(causeMem2Hazard), "ctrlCmd mem2 hazard");
        stepCycle(idInstr, '0);
        checkCmd(ctrlCmd, expectedRow(causeNone), "ctrlCmd after load");

        // Register zero and unused sources
        stepCycle(makeInstr(5'd0, 1'b1, 5'd1, 1'b1, 5'd2, 1'b1), '0);
        stepCycle(makeInstr(5'd4, 1'b0, 5'd0, 1'b1, 5'd0, 1'b1), '0);
        checkCmd(ctrlCmd, expectedRow(causeNone), "ctrlCmd r0 dependency");
        stepCycle(makeInstr(5'd7, 1'b1, 5'd1, 1'b0, 5'd2, 1'b0), '0);
        stepCycle(makeInstr(5'd8, 1'b0, 5'd3, 1'b1, 5'd7, 1'b0), '0);
        checkCmd(ctrlCmd, expectedRow(causeNone), "ctrlCmd unused source");

        // First drain, until model and DUT WB are both empty
        waitCount = 0;
        while ((mEx.valid || mMem1.valid || mMem2.valid || mWb.valid || wbInstr.valid) &&
               waitCount < 20) begin
            stepCycle('0, '0);
            waitCount++;
        end
        if (mEx.valid || mMem1.valid || mMem2.valid || mWb.valid || wbInstr.valid) begin
            errCount++;
            $display("timeout: pipeline did not drain within 20 cycles");
        end

        // One instruction through an empty pipe
        marker = makeInstr(5'd9, 1'b0, 5'd10, 1'b1, 5'd11, 1'b1);
        stepCycle(marker, '0);
        waitCount = 0;
        while (!wbInstr.valid && waitCount < 10) begin
            stepCycle('0, '0);
            waitCount++;
        end
        if (!wbInstr.valid) begin
            errCount++;
            $display("timeout: instruction never reached WB");
        end else begin
            checkInstr(wbInstr, marker, "wbInstr latency");
            if (waitCount != 4) begin
                errCount++;
                $display("mismatch at %0t: wb latency got %0d, expected 4", $time, waitCount);
            end
        end

        // Random traffic against the model
        repeat (3000) begin
            stepCycle(randomInstr(), randomStalls());
        end

        $display("Run finished with %0d checks and %0d errors", checkCount, errCount);
        if (errCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
rtl/PipeCtrlPkg.sv
rtl/HazardDetect.sv
rtl/StallFlushCtrl.sv
rtl/StageTrack.sv
rtl/PipeCtrlTop.sv
bench/PipeCtrlTb.sv

// File: Bender.yml
package:
  name: pipe_ctrl

sources:
  - rtl/PipeCtrlPkg.sv
  - rtl/HazardDetect.sv
  - rtl/StallFlushCtrl.sv
  - rtl/StageTrack.sv
  - rtl/PipeCtrlTop.sv
  - target: test
    files:
      - bench/PipeCtrlTb.sv
